//--- compile.f
mem_pkg.sv
mem_bank_router.sv
mem_delayed_bank.sv
mem_rsp_merge.sv
mem_banked_top.sv
tb_mem_banked.sv

//--- run_sim.sh
#!/usr/bin/env bash
# builds the banked memory testbench with Verilator, runs it and scans the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir
verilator --binary --timing --assert --top-module tb_mem_banked -f compile.f \
    -o sim_mem_banked > build.log 2>&1 \
    || { cat build.log; echo "Verilator build failed"; exit 1; }
# a simulator that stops on its own error counts as a failed run
./obj_dir/sim_mem_banked > sim.log 2>&1 || echo "Simulation failed" >> sim.log
cat sim.log
grep -q "Simulation failed" sim.log && { echo "FAIL"; exit 1; } || { echo "PASS"; exit 0; }

//--- tb_mem_banked.sv
`timescale 1ns/1ps

module tb_mem_banked;

    localparam int NUM_BANKS  = 4;
    localparam int BANK_WORDS = 16;
    localparam int MEM_DELAY  = 3;

    localparam int aw = mem_pkg::addr_width;
    localparam int dw = mem_pkg::data_width;
    localparam int tw = mem_pkg::tag_width;

    localparam int sel_w       = $clog2(NUM_BANKS);
    localparam int total_words = NUM_BANKS * BANK_WORDS;
    localparam int word_w      = $clog2(total_words);

    // test schedule sizes
    localparam int n_pairs     = 8;
    localparam int n_bursts    = 4;
    localparam int hold_cycles = 6;
    localparam int n_drains    = n_bursts + 3;
    localparam int n_requests  = total_words + 2 * n_pairs + n_bursts * NUM_BANKS + 2;

    // a request that has to wait for its bank never costs more than a full bank turnaround
    localparam int req_cost       = MEM_DELAY + 3;
    localparam int test_cycles    = 4 + 8 + total_words + 4 + n_requests * req_cost
                                    + n_drains * req_cost + hold_cycles + 8;
    localparam int timeout_cycles = test_cycles + 20 * MEM_DELAY;

    // one expected response, in issue order
    typedef struct packed {
        mem_pkg::mem_op_t op;
        logic [tw - 1:0]  tag;
        logic [dw - 1:0]  data;
        logic [2:0]       test_id;
        int               due;
    } exp_t;

    logic                clk = 1'b0;
    logic                rst;
    logic                ena;
    logic                req_valid;
    mem_pkg::mem_req_t   req;
    logic                oob_valid;
    mem_pkg::oob_wr_t    oob;
    logic [NUM_BANKS - 1:0] bank_busy;
    logic                rsp_valid;
    mem_pkg::mem_rsp_t   rsp;

    // reference memory, indexed by the global word address
    logic [dw - 1:0]     ref_mem [total_words];
    exp_t                exp_q [$];

    // slot in which each bank last got a request, since busy only shows two edges later
    int                  last_issue [NUM_BANKS];
    int                  cycle = 0;
    int                  check_errs = 0;
    int                  assert_errs = 0;
    int                  rsp_count = 0;
    logic                seen_req = 1'b0;
    logic [31:0]         lfsr = 32'h229b;

    mem_banked_top #(
        .NUM_BANKS  (NUM_BANKS),
        .BANK_WORDS (BANK_WORDS),
        .MEM_DELAY  (MEM_DELAY)
    ) UUT (
        .clk       (clk),
        .rst       (rst),
        .ena       (ena),
        .req_valid (req_valid),
        .req       (req),
        .oob_valid (oob_valid),
        .oob       (oob),
        .bank_busy (bank_busy),
        .rsp_valid (rsp_valid),
        .rsp       (rsp)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    // galois form of x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    // one LFSR step per bit handed out
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v    = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic string test_label(input logic [2:0] id);
        case (id)
            3'd2:    return "preload_read";
            3'd3:    return "write_read";
            3'd4:    return "latency";
            3'd5:    return "burst";
            3'd6:    return "hold_disabled";
            default: return "unknown";
        endcase
    endfunction

    task automatic check_value(input string test, input string what,
                               input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            check_errs++;
            $display("** Error [%s] %s: expected 0x%0h, actual 0x%0h", test, what, exp, act);
        end
    endtask

    task automatic report_violation(input string msg);
        assert_errs++;
        $display("assertion failed at cycle %0d: %s", cycle, msg);
    endtask

    task automatic print_counts();
        $display("responses checked %0d, compare errors %0d, assertion errors %0d",
                 rsp_count, check_errs, assert_errs);
    endtask

    // every drive happens half a nanosecond after a rising edge
    task automatic next_slot();
        @(posedge clk);
        #0.5;
    endtask

    task automatic drain();
        while (exp_q.size() != 0) begin
            next_slot();
        end
    endtask

    // waits until the addressed bank is free, then drives a one-cycle request
    // extra is the number of edges the bank will sit with ena low after capture
    task automatic issue_req(input mem_pkg::mem_op_t op, input int word,
                             input logic [dw - 1:0] data, input logic [tw - 1:0] tag,
                             input int extra, input logic [2:0] test_id);
        int   b;
        exp_t e;
        b = word % NUM_BANKS;
        while (bank_busy[b] || (last_issue[b] == cycle - 1)) begin
            next_slot();
        end
        req.op      = op;
        req.addr    = aw'(word) << 2;
        req.wr_data = data;
        req.tag     = tag;
        req_valid   = 1'b1;
        seen_req    = 1'b1;
        last_issue[b] = cycle;
        e.op      = op;
        e.tag     = tag;
        e.test_id = test_id;
        if (op == mem_pkg::op_write) begin
            ref_mem[word] = data;
            e.data        = '0;
        end else begin
            e.data = ref_mem[word];
        end
        // sampled by the router on the next edge, answered MEM_DELAY+2 edges after that
        e.due = cycle + 1 + MEM_DELAY + 2 + extra;
        exp_q.push_back(e);
        next_slot();
        req_valid = 1'b0;
    endtask

    // responses are compared on the falling edge, where the registered outputs are settled
    always @(negedge clk) begin : rsp_compare
        exp_t e;
        if (!rst) begin
            if (rsp_valid) begin
                if (exp_q.size() == 0) begin
                    check_errs++;
                    $display("response at cycle %0d arrived with no request outstanding", cycle);
                end else begin
                    e = exp_q.pop_front();
                    rsp_count++;
                    check_value(test_label(e.test_id), "response cycle", e.due, cycle);
                    check_value(test_label(e.test_id), "op", 32'(e.op), 32'(rsp.op));
                    check_value(test_label(e.test_id), "tag", 32'(e.tag), 32'(rsp.tag));
                    check_value(test_label(e.test_id), "rd_data", e.data, rsp.rd_data);
                end
            end else if (exp_q.size() != 0 && exp_q[0].due < cycle) begin
                e = exp_q.pop_front();
                check_errs++;
                $display("no response for tag 0x%0h, it was due at cycle %0d", e.tag, e.due);
            end
        end
    end

    // nothing is busy and nothing answers before the first request
    a_idle_after_reset : assert property (@(posedge clk) disable iff (rst)
        !seen_req |-> (bank_busy == '0 && !rsp_valid))
        else report_violation("bank_busy or rsp_valid high before any request");

    // an ack can only come from an edge where ena was high, one register stage earlier
    a_no_rsp_while_disabled : assert property (@(posedge clk) disable iff (rst)
        !$past(ena, 2) |-> !rsp_valid)
        else report_violation("response appeared while ena was low");

    for (genvar b = 0; b < NUM_BANKS; b++) begin : g_busy_chk
        // busy is set on the bank capture edge, one edge after the router took the request
        a_busy_after_req : assert property (@(posedge clk) disable iff (rst)
            ($past(req_valid, 2) && ($past(req.addr[2 +: sel_w], 2) == sel_w'(b)))
            |-> bank_busy[b])
            else report_violation("bank_busy not high one cycle after its request");

        // busy drops on the ack edge and the merger registers that ack one edge later
        a_busy_ends_at_ack : assert property (@(posedge clk) disable iff (rst)
            $fell(bank_busy[b]) |=> rsp_valid)
            else report_violation("bank_busy fell without a response following it");
    end

    initial begin : watchdog
        while (cycle < timeout_cycles) begin
            @(posedge clk);
        end
        $display("timeout: run did not finish within %0d cycles", timeout_cycles);
        print_counts();
        $display("Simulation failed");
        $finish;
    end

    initial begin : stimulus
        logic [dw - 1:0] d;
        int              wd;
        int              base;
        rst       = 1'b1;
        ena       = 1'b0;
        req_valid = 1'b0;
        req       = '0;
        oob_valid = 1'b0;
        oob       = '0;
        for (int i = 0; i < NUM_BANKS; i++) begin
            last_issue[i] = -8;
        end
        repeat (4) @(posedge clk);
        #0.5;
        rst = 1'b0;

        // idle stretch, watched by the reset assertion
        repeat (6) next_slot();

        // preload every word while processing is held off
        for (int w = 0; w < total_words; w++) begin
            d         = take_bits(dw);
            oob.addr  = aw'(w) << 2;
            oob.data  = d;
            oob_valid = 1'b1;
            ref_mem[w] = d;
            next_slot();
        end
        oob_valid = 1'b0;
        repeat (3) next_slot();
        ena = 1'b1;
        next_slot();
        for (int w = 0; w < total_words; w++) begin
            issue_req(mem_pkg::op_read, w, '0, tw'(take_bits(tw)), 0, 3'd2);
        end

        // write then read back the same word, the read waits for the bank on its own
        for (int n = 0; n < n_pairs; n++) begin
            wd = take_bits(word_w);
            d  = take_bits(dw);
            issue_req(mem_pkg::op_write, wd, d, tw'(take_bits(tw)), 0, 3'd3);
            issue_req(mem_pkg::op_read, wd, '0, tw'(take_bits(tw)), 0, 3'd3);
        end

        // a lone request on an idle memory
        drain();
        issue_req(mem_pkg::op_read, take_bits(word_w), '0, tw'(take_bits(tw)), 0, 3'd4);

        // consecutive words sit in consecutive banks, so a burst keeps every bank in flight
        for (int n = 0; n < n_bursts; n++) begin
            drain();
            base = take_bits(word_w);
            for (int i = 0; i < NUM_BANKS; i++) begin
                wd = (base + i) % total_words;
                if (take_bits(1) == 32'd1) begin
                    issue_req(mem_pkg::op_write, wd, take_bits(dw), tw'(take_bits(tw)), 0, 3'd5);
                end else begin
                    issue_req(mem_pkg::op_read, wd, '0, tw'(take_bits(tw)), 0, 3'd5);
                end
            end
        end

        // request captured with ena low; the issue task returns one slot after the drive,
        // so the bank sees hold_cycles-1 disabled edges after its capture edge
        drain();
        ena = 1'b0;
        issue_req(mem_pkg::op_read, take_bits(word_w), '0, tw'(take_bits(tw)),
                  hold_cycles - 1, 3'd6);
        repeat (hold_cycles) next_slot();
        ena = 1'b1;

        drain();
        repeat (4) next_slot();
        print_counts();
        if (check_errs == 0 && assert_errs == 0 && rsp_count == n_requests) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

//--- mem_banked_top.sv
`timescale 1ns/1ps

module mem_banked_top #(
    parameter int NUM_BANKS  = 4,
    parameter int BANK_WORDS = 256,
    parameter int MEM_DELAY  = 3
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   ena,

    input  logic                   req_valid,
    input  mem_pkg::mem_req_t      req,
    input  logic                   oob_valid,
    input  mem_pkg::oob_wr_t       oob,

    output logic [NUM_BANKS - 1:0] bank_busy,
    output logic                   rsp_valid,
    output mem_pkg::mem_rsp_t      rsp
);

    // router to banks, one strobe per bank and a shared payload per path
    logic [NUM_BANKS - 1:0] bank_req_valid;
    mem_pkg::mem_req_t      bank_req;
    logic [NUM_BANKS - 1:0] bank_oob_valid;
    mem_pkg::oob_wr_t       bank_oob;

    // banks to merger
    logic [NUM_BANKS - 1:0] bank_ack;
    mem_pkg::mem_rsp_t      bank_rsp [NUM_BANKS];

    mem_bank_router #(
        .NUM_BANKS  (NUM_BANKS),
        .BANK_WORDS (BANK_WORDS)
    ) u_router (
        .clk            (clk),
        .rst            (rst),
        .req_valid      (req_valid),
        .req            (req),
        .oob_valid      (oob_valid),
        .oob            (oob),
        .bank_req_valid (bank_req_valid),
        .bank_req       (bank_req),
        .bank_oob_valid (bank_oob_valid),
        .bank_oob       (bank_oob)
    );

    // all banks share the payload buses and differ only in their strobe bit
    for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank
        mem_delayed_bank #(
            .BANK_WORDS (BANK_WORDS),
            .MEM_DELAY  (MEM_DELAY)
        ) u_bank (
            .clk       (clk),
            .rst       (rst),
            .ena       (ena),
            .req_valid (bank_req_valid[b]),
            .req       (bank_req),
            .oob_valid (bank_oob_valid[b]),
            .oob       (bank_oob),
            .busy      (bank_busy[b]),
            .ack       (bank_ack[b]),
            .rsp       (bank_rsp[b])
        );
    end

    mem_rsp_merge #(
        .NUM_BANKS (NUM_BANKS)
    ) u_merge (
        .clk       (clk),
        .rst       (rst),
        .bank_ack  (bank_ack),
        .bank_rsp  (bank_rsp),
        .rsp_valid (rsp_valid),
        .rsp       (rsp)
    );

endmodule

//--- mem_rsp_merge.sv
`timescale 1ns/1ps

module mem_rsp_merge #(
    parameter int NUM_BANKS = 4
) (
    input  logic                   clk,
    input  logic                   rst,

    input  logic [NUM_BANKS - 1:0] bank_ack,
    input  mem_pkg::mem_rsp_t      bank_rsp [NUM_BANKS],

    output logic                   rsp_valid,
    output mem_pkg::mem_rsp_t      rsp
);

    localparam int rsp_w = $bits(mem_pkg::mem_rsp_t);

    // response of whichever bank acked this cycle, zero when none did
    logic [rsp_w - 1:0] rsp_sel;

    // each bank response is masked by its own ack and the results are ORed together
    // with at most one ack high this is a plain one-hot mux
    always_comb begin
        rsp_sel = '0;
        for (int i = 0; i < NUM_BANKS; i++) begin
            rsp_sel = rsp_sel | ({rsp_w{bank_ack[i]}} & rsp_w'(bank_rsp[i]));
        end
    end

    // one valid pulse follows each bank ack
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rsp_valid <= 1'b0;
        end else begin
            rsp_valid <= |bank_ack;
        end
    end

    // the payload is only loaded when some bank acked, and holds otherwise
    always_ff @(posedge clk) begin
        if (|bank_ack) begin
            rsp <= mem_pkg::mem_rsp_t'(rsp_sel);
        end
    end

    // requests enter one per cycle and the delay is fixed, so two banks never finish together
    // a second ack in the same cycle would be ORed into a corrupt response
    a_ack_onehot : assert property (@(posedge clk) disable iff (rst)
        $onehot0(bank_ack));

endmodule

//--- mem_delayed_bank.sv
`timescale 1ns/1ps

module mem_delayed_bank #(
    parameter int BANK_WORDS = 256,
    parameter int MEM_DELAY  = 3
) (
    input  logic              clk,
    input  logic              rst,

    // while ena is low a captured request is held with its counter frozen
    // this lets the testbench preload memory before any request is processed
    input  logic              ena,

    input  logic              req_valid,
    input  mem_pkg::mem_req_t req,

    // preload port, accepted whether or not a request is pending
    input  logic              oob_valid,
    input  mem_pkg::oob_wr_t  oob,

    output logic              busy,
    output logic              ack,
    output mem_pkg::mem_rsp_t rsp
);

    // width of the local word index into the bank array
    localparam int idx_w = (BANK_WORDS > 1) ? $clog2(BANK_WORDS) : 1;

    // the counter has to hold MEM_DELAY-1; keep at least one bit for a delay of one
    localparam int cnt_w = (MEM_DELAY > 1) ? $clog2(MEM_DELAY) : 1;

    // word storage of this bank
    logic [mem_pkg::data_width - 1:0] mem [BANK_WORDS];

    // the one stored request; busy doubles as its valid flag
    mem_pkg::mem_req_t                st_req;

    // cycles left before the stored request completes
    logic [cnt_w - 1:0]               wait_cnt;

    // local indexes taken from the address fields the router already reduced
    logic [idx_w - 1:0]               st_idx;
    logic [idx_w - 1:0]               oob_idx;

    // a new request is taken only when nothing is stored
    logic                             accept;

    // the stored request finishes on this edge
    logic                             done;

    assign st_idx  = st_req.addr[idx_w - 1:0];
    assign oob_idx = oob.addr[idx_w - 1:0];

    assign accept = req_valid && !busy;

    // completion needs ena high, so a request captured with ena low waits here
    assign done = busy && ena && (wait_cnt == '0);

    // control path
    // busy rises on the capture edge and falls on the edge where ack rises,
    // so ack and the memory update happen together
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy     <= 1'b0;
            ack      <= 1'b0;
            wait_cnt <= '0;
        end else begin
            ack <= done;
            if (done) begin
                busy <= 1'b0;
            end else if (busy) begin
                // the count only moves on enabled cycles
                if (ena) begin
                    wait_cnt <= wait_cnt - 1'b1;
                end
            end else if (accept) begin
                busy     <= 1'b1;
                wait_cnt <= cnt_w'(MEM_DELAY - 1);
            end
        end
    end

    // request capture
    always_ff @(posedge clk) begin
        if (accept) begin
            st_req <= req;
        end
    end

    // memory array and response payload
    // the preload write goes first so that a completing request write to the same word wins
    always_ff @(posedge clk) begin
        if (oob_valid) begin
            mem[oob_idx] <= oob.data;
        end
        if (done) begin
            if (st_req.op == mem_pkg::op_write) begin
                mem[st_idx] <= st_req.wr_data;
            end
            rsp.op  <= st_req.op;
            rsp.tag <= st_req.tag;
            // writes return zero so that the merged response bus stays clean
            if (st_req.op == mem_pkg::op_read) begin
                rsp.rd_data <= mem[st_idx];
            end else begin
                rsp.rd_data <= '0;
            end
        end
    end

    // the router only gets one request per bank in flight if the requester watches bank_busy
    a_no_req_while_busy : assert property (@(posedge clk) disable iff (rst)
        req_valid |-> !busy);

    // a request has to be captured and counted again before another ack can follow
    a_ack_single_cycle : assert property (@(posedge clk) disable iff (rst)
        ack |=> !ack);

endmodule

//--- mem_bank_router.sv
`timescale 1ns/1ps

module mem_bank_router #(
    parameter int NUM_BANKS  = 4,
    parameter int BANK_WORDS = 256
) (
    input  logic                   clk,
    input  logic                   rst,

    input  logic                   req_valid,
    input  mem_pkg::mem_req_t      req,
    input  logic                   oob_valid,
    input  mem_pkg::oob_wr_t       oob,

    output logic [NUM_BANKS - 1:0] bank_req_valid,
    output mem_pkg::mem_req_t      bank_req,
    output logic [NUM_BANKS - 1:0] bank_oob_valid,
    output mem_pkg::oob_wr_t       bank_oob
);

    // number of word-address bits that pick the bank
    localparam int sel_w = $clog2(NUM_BANKS);

    // the two low byte bits plus the bank bits sit below the local word index
    localparam int idx_shift = 2 + sel_w;

    logic [sel_w - 1:0]                req_sel;
    logic [sel_w - 1:0]                oob_sel;
    logic [mem_pkg::addr_width - 1:0]  req_idx;
    logic [mem_pkg::addr_width - 1:0]  oob_idx;

    mem_pkg::mem_req_t                 req_local;
    mem_pkg::oob_wr_t                  oob_local;

    // banks are interleaved on the word address, so consecutive words land in different banks
    assign req_sel = req.addr[2 +: sel_w];
    assign oob_sel = oob.addr[2 +: sel_w];

    // everything above the bank bits becomes the word index inside the bank
    assign req_idx = req.addr >> idx_shift;
    assign oob_idx = oob.addr >> idx_shift;

    // same payload as received, only the address is rewritten to the local index
    always_comb begin
        req_local      = req;
        req_local.addr = req_idx;
        oob_local      = oob;
        oob_local.addr = oob_idx;
    end

    // exactly one bank strobe is raised for each incoming request or preload write
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            bank_req_valid <= '0;
            bank_oob_valid <= '0;
        end else begin
            bank_req_valid <= req_valid ? (NUM_BANKS'(1) << req_sel) : '0;
            bank_oob_valid <= oob_valid ? (NUM_BANKS'(1) << oob_sel) : '0;
        end
    end

    // one shared payload register per path; the strobe vector says which bank takes it
    always_ff @(posedge clk) begin
        if (req_valid) begin
            bank_req <= req_local;
        end
        if (oob_valid) begin
            bank_oob <= oob_local;
        end
    end

    // the banks ignore the two byte bits, so a misaligned address would silently alias
    a_req_aligned : assert property (@(posedge clk) disable iff (rst)
        req_valid |-> (req.addr[1:0] == 2'b00));

    // an address past the end of the banked space would wrap inside the bank array
    a_req_in_range : assert property (@(posedge clk) disable iff (rst)
        req_valid |-> (req_idx < BANK_WORDS));

endmodule

//--- mem_pkg.sv
package mem_pkg;

    // byte address width seen by the requester
    localparam int addr_width = 32;

    // width of one memory word
    localparam int data_width = 32;

    // width of the tag that travels with each request and comes back on its response
    localparam int tag_width = 4;

    // the two operations a bank can perform
    typedef enum logic {
        op_read  = 1'b0,
        op_write = 1'b1
    } mem_op_t;

    // one request from the requester
    // addr is a word aligned byte address at the top level; past the router it holds the
    // local word index inside the selected bank
    typedef struct packed {
        mem_op_t                 op;
        logic [addr_width - 1:0] addr;
        logic [data_width - 1:0] wr_data;
        logic [tag_width - 1:0]  tag;
    } mem_req_t;

    // one response, returned once per request
    // rd_data is only meaningful for reads and is zero for writes
    typedef struct packed {
        mem_op_t                 op;
        logic [data_width - 1:0] rd_data;
        logic [tag_width - 1:0]  tag;
    } mem_rsp_t;

    // out-of-band preload write, used to fill memory while ena is low
    // the router reduces addr to the local word index, the same way as for requests
    typedef struct packed {
        logic [addr_width - 1:0] addr;
        logic [data_width - 1:0] data;
    } oob_wr_t;

endpackage
